//--- common/cpuIdConfigPkg.sv
`default_nettype none

package cpuIdConfigPkg;

	// widths of the query unit
	localparam int idWidth = 64;
	localparam int queryIndexWidth = 5;
	localparam int timerWidth = 12;
	localparam int rngWidth = 32;
	localparam int variantWidth = 4;

	// identification table geometry
	localparam int tableSlotWidth = 4;
	localparam int tableDepth = 1 << tableSlotWidth;

	// index map
	// 0..15 table, 16..30 zero, 31 noise
	localparam int zeroBase = 16;
	localparam int noiseIndex = 31;

	// one word of the answer
	typedef logic [idWidth-1:0] idWord_t;

	// request fields
	typedef logic [queryIndexWidth-1:0] queryIndex_t;
	typedef logic [timerWidth-1:0] timerWord_t;

	// table slot, low bits of the index
	typedef logic [tableSlotWidth-1:0] tableSlot_t;

	// one half of the noise generator
	typedef logic [rngWidth-1:0] rngWord_t;

	// core variant field of entry 1
	typedef logic [variantWidth-1:0] coreVariant_t;

	// architecture signature for entry 0
	// ASCII "QX64A0  ", first character in the low byte
	localparam idWord_t archSignature = 64'h2020304134365851;

endpackage

`default_nettype wire

//--- common/cpuIdPipePkg.sv
`default_nettype none

package cpuIdPipePkg;

	// what kind of answer a query gets
	typedef enum logic [1:0] {
		tableRead,
		timerRead,
		zeroRead,
		noiseRead
	} queryClass_e;

	// request as it arrives at the unit, 17 bits
	typedef struct packed {
		cpuIdConfigPkg::queryIndex_t index;
		cpuIdConfigPkg::timerWord_t timer;
	} queryReq_t;

	// request after decode
	// the slot only matters for table reads
	typedef struct packed {
		queryClass_e queryClass;
		cpuIdConfigPkg::tableSlot_t slot;
		cpuIdConfigPkg::timerWord_t timer;
	} decodedQuery_t;

	// 128-bit answer
	// high word sits in the upper bits of the packed value
	typedef struct packed {
		cpuIdConfigPkg::idWord_t resHi;
		cpuIdConfigPkg::idWord_t resLo;
	} queryAnswer_t;

endpackage

`default_nettype wire

//--- src/noiseRng.sv
`default_nettype none

module noiseRng #(
	parameter cpuIdConfigPkg::rngWord_t [1:0] rngSeed = {32'h1D872B41, 32'h6C078965}
) (
	input logic clock,
	input logic reset,
	input logic timerBit,
	output cpuIdConfigPkg::idWord_t noise
);
	import cpuIdConfigPkg::*;

	// two coupled halves
	rngWord_t rngA;
	rngWord_t rngB;
	rngWord_t nextA;
	rngWord_t nextB;

	// feedback bits and their copies from the last cycle
	logic fbA;
	logic fbB;
	logic fbALast;
	logic fbBLast;

	// timer bit edge filter
	logic timerSync;
	logic timerLast;
	logic timerNoise;

	always_comb begin
		fbA = rngA[1] ^ rngA[3] ^ rngA[5] ^ rngA[7] ^ timerNoise ^ fbBLast ^ 1'b1;
		fbB = rngB[1] ^ rngB[3] ^ rngB[5] ^ rngB[7] ^ timerNoise ^ fbALast ^ 1'b1;
		// shift right, new bit enters at the top
		nextA = {fbA, rngA[rngWidth-1:1]};
		nextB = {fbB, rngB[rngWidth-1:1]};
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rngA <= rngSeed[1];
			rngB <= rngSeed[0];
			fbALast <= 1'b0;
			fbBLast <= 1'b0;
			timerSync <= 1'b0;
			timerLast <= 1'b0;
			timerNoise <= 1'b0;
		end else begin
			rngA <= nextA;
			rngB <= nextB;
			fbALast <= fbA;
			fbBLast <= fbB;
			timerSync <= timerBit;
			timerLast <= timerSync;
			// toggles of the timer bit only
			timerNoise <= timerSync ^ timerLast;
		end
	end

	// nibbles interleaved, A from the top down and B from the bottom up
	assign noise = {
		rngA[31:28], rngB[3:0],
		rngA[27:24], rngB[7:4],
		rngA[23:20], rngB[11:8],
		rngA[19:16], rngB[15:12],
		rngA[15:12], rngB[19:16],
		rngA[11:8], rngB[23:20],
		rngA[7:4], rngB[27:24],
		rngA[3:0], rngB[31:28]
	};

	// a stuck half would make the noise word repeat
	noiseNotStuck: assert property (@(posedge clock) disable iff (reset)
		rngA != '0 && rngA != '1 && rngB != '0 && rngB != '1)
		else $error("noiseRng: generator half reached a stuck value");

endmodule

`default_nettype wire

//--- pipeline/queryDecode.sv
`default_nettype none

module queryDecode (
	input logic clock,
	input logic reset,

	input logic reqValid,
	output logic reqReady,
	input cpuIdPipePkg::queryReq_t req,

	output logic decValid,
	input logic decReady,
	output cpuIdPipePkg::decodedQuery_t dec
);
	import cpuIdConfigPkg::*;
	import cpuIdPipePkg::*;

	decodedQuery_t decNext;
	logic reqFire;

	// single register stage, refills while draining
	assign reqReady = !decValid || decReady;
	assign reqFire = reqValid && reqReady;

	always_comb begin
		decNext.slot = req.index[tableSlotWidth-1:0];
		decNext.timer = req.timer;
		if (req.index == queryIndex_t'(noiseIndex)) begin
			decNext.queryClass = noiseRead;
		end else if (req.index >= queryIndex_t'(zeroBase)) begin
			decNext.queryClass = zeroRead;
		end else if (req.index == queryIndex_t'(1)) begin
			// entry 1 carries the live timer nibble
			decNext.queryClass = timerRead;
		end else begin
			decNext.queryClass = tableRead;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decValid <= 1'b0;
		end else if (reqFire) begin
			decValid <= 1'b1;
		end else if (decReady) begin
			decValid <= 1'b0;
		end
	end

	// payload only moves on an accepted request
	always_ff @(posedge clock) begin
		if (reqFire) begin
			dec <= decNext;
		end
	end

	decHeld: assert property (@(posedge clock) disable iff (reset)
		decValid && !decReady |=> decValid && $stable(dec))
		else $error("queryDecode: dec changed while stalled");

endmodule

`default_nettype wire

//--- pipeline/queryExecute.sv
`default_nettype none

module queryExecute #(
	parameter cpuIdConfigPkg::coreVariant_t coreVariant = '0
) (
	input logic clock,
	input logic reset,

	input logic decValid,
	output logic decReady,
	input cpuIdPipePkg::decodedQuery_t dec,

	input cpuIdConfigPkg::idWord_t noise,

	output logic exeValid,
	input logic exeReady,
	output cpuIdPipePkg::queryAnswer_t exe
);
	import cpuIdConfigPkg::*;
	import cpuIdPipePkg::*;

	// entry 1 layout
	// variant in bits 7:4, bits 3:0 filled from the timer on a read
	localparam idWord_t variantWord = idWord_t'({coreVariant, 4'h0});

	// identification table
	// only the first two entries carry data for now
	localparam idWord_t idTable [tableDepth] = '{
		0: archSignature,
		1: variantWord,
		default: '0
	};

	queryAnswer_t exeNext;
	idWord_t tableWord;
	logic decFire;

	assign decReady = !exeValid || exeReady;
	assign decFire = decValid && decReady;

	assign tableWord = idTable[dec.slot];

	always_comb begin
		// high word is reserved, always zero
		exeNext.resHi = '0;
		case (dec.queryClass)
			tableRead: begin
				exeNext.resLo = tableWord;
			end
			timerRead: begin
				// upper timer nibble replaces the low nibble
				exeNext.resLo = {idTable[1][idWidth-1:4], dec.timer[timerWidth-1:timerWidth-4]};
			end
			zeroRead: begin
				exeNext.resLo = '0;
			end
			noiseRead: begin
				// generator output in the cycle the item is captured
				exeNext.resLo = noise;
			end
			default: begin
				exeNext.resLo = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			exeValid <= 1'b0;
		end else if (decFire) begin
			exeValid <= 1'b1;
		end else if (exeReady) begin
			exeValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (decFire) begin
			exe <= exeNext;
		end
	end

	// no path may ever fill the reserved word
	resHiZero: assert property (@(posedge clock) disable iff (reset)
		exeValid |-> exe.resHi == '0)
		else $error("queryExecute: resHi is not zero");

endmodule

`default_nettype wire

//--- pipeline/queryResult.sv
`default_nettype none

module queryResult (
	input logic clock,
	input logic reset,

	input logic exeValid,
	output logic exeReady,
	input cpuIdPipePkg::queryAnswer_t exe,

	output logic ansValid,
	input logic ansReady,
	output cpuIdPipePkg::queryAnswer_t ans
);
	import cpuIdPipePkg::*;

	queryAnswer_t ansReg;
	logic exeFire;
	logic ansFire;

	// accept when empty or when the held answer leaves this cycle
	assign exeReady = !ansValid || ansReady;
	assign exeFire = exeValid && exeReady;
	assign ansFire = ansValid && ansReady;

	always_ff @(posedge clock) begin
		if (reset) begin
			ansValid <= 1'b0;
		end else if (exeFire) begin
			ansValid <= 1'b1;
		end else if (ansFire) begin
			ansValid <= 1'b0;
		end
	end

	// held until the consumer takes it
	always_ff @(posedge clock) begin
		if (exeFire) begin
			ansReg <= exe;
		end
	end

	assign ans = ansReg;

	ansHeld: assert property (@(posedge clock) disable iff (reset)
		ansValid && !ansReady |=> ansValid && $stable(ans))
		else $error("queryResult: ans changed under back-pressure");

endmodule

`default_nettype wire

//--- src/cpuIdTop.sv
`default_nettype none

module cpuIdTop #(
	parameter cpuIdConfigPkg::coreVariant_t coreVariant = '0,
	parameter cpuIdConfigPkg::rngWord_t [1:0] rngSeed = {32'h1D872B41, 32'h6C078965}
) (
	input logic clock,
	input logic reset,

	input logic reqValid,
	output logic reqReady,
	input cpuIdPipePkg::queryReq_t req,

	output logic ansValid,
	input logic ansReady,
	output cpuIdPipePkg::queryAnswer_t ans
);
	import cpuIdConfigPkg::*;
	import cpuIdPipePkg::*;

	// decode to execute
	logic decValid;
	logic decReady;
	decodedQuery_t dec;

	// execute to result
	logic exeValid;
	logic exeReady;
	queryAnswer_t exe;

	// free-running noise word
	idWord_t noise;

	queryDecode decodeStage (
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req),
		.decValid(decValid),
		.decReady(decReady),
		.dec(dec)
	);

	queryExecute #(
		.coreVariant(coreVariant)
	) executeStage (
		.clock(clock),
		.reset(reset),
		.decValid(decValid),
		.decReady(decReady),
		.dec(dec),
		.noise(noise),
		.exeValid(exeValid),
		.exeReady(exeReady),
		.exe(exe)
	);

	queryResult resultStage (
		.clock(clock),
		.reset(reset),
		.exeValid(exeValid),
		.exeReady(exeReady),
		.exe(exe),
		.ansValid(ansValid),
		.ansReady(ansReady),
		.ans(ans)
	);

	// entropy from the live timer on the request port
	noiseRng #(
		.rngSeed(rngSeed)
	) noiseGen (
		.clock(clock),
		.reset(reset),
		.timerBit(req.timer[0]),
		.noise(noise)
	);

endmodule

`default_nettype wire

//--- testbench/cpuIdTb.sv
`default_nettype none

module cpuIdTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpuIdConfigPkg::*;
	import cpuIdPipePkg::*;

	// own copies of the DUT configuration
	localparam coreVariant_t variantValue = 4'hA;
	localparam idWord_t signatureValue = 64'h2020304134365851;
	localparam rngWord_t [1:0] seedValue = {32'h1D872B41, 32'h6C078965};
	localparam int waitLimit = 200;

	// ansReady modes
	localparam int readyRandom = 0;
	localparam int readyLow = 1;
	localparam int readyHigh = 2;

	// one pending answer of the reference model
	typedef struct packed {
		logic isNoise;
		idWord_t resLo;
	} expected_t;

	logic clock;
	logic reset;
	logic reqValid;
	logic reqReady;
	queryReq_t req;
	logic ansValid;
	logic ansReady;
	queryAnswer_t ans;

	expected_t expectQueue[$];
	idWord_t noiseSeen[$];
	int stallAccepts;
	int readyMode;
	logic stallPhase;
	logic [31:0] stimState;
	logic [31:0] readyState;

	cpuIdTop #(
		.coreVariant(variantValue),
		.rngSeed(seedValue)
	) DUT (
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req),
		.ansValid(ansValid),
		.ansReady(ansReady),
		.ans(ans)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// low word as the index map defines it, noise excluded
	function automatic idWord_t expectedLo(input queryIndex_t index, input timerWord_t timer);
		if (index == 5'd0) begin
			return signatureValue;
		end else if (index == 5'd1) begin
			return {56'h0, variantValue, timer[11:8]};
		end
		return '0;
	endfunction

	task automatic stopWithFailure();
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string name, input idWord_t expected, input idWord_t actual);
		$display("FAILED at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
		stopWithFailure();
	endtask

	task automatic reportProblem(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		stopWithFailure();
	endtask

	task automatic driveRequest(input queryIndex_t index, input timerWord_t timer);
		@(negedge clock);
		reqValid = 1'b1;
		req.index = index;
		req.timer = timer;
	endtask

	task automatic awaitAccept();
		for (int waited = 0; waited < waitLimit; waited++) begin
			@(posedge clock);
			if (reqReady) begin
				return;
			end
		end
		reportProblem("request was not accepted before the timeout");
	endtask

	task automatic sendRequest(input queryIndex_t index, input timerWord_t timer);
		driveRequest(index, timer);
		awaitAccept();
	endtask

	task automatic endRequests();
		@(negedge clock);
		reqValid = 1'b0;
	endtask

	task automatic setReadyMode(input int mode);
		@(posedge clock);
		readyMode = mode;
	endtask

	task automatic drainAll();
		for (int waited = 0; waited < waitLimit; waited++) begin
			@(negedge clock);
			if (expectQueue.size() == 0 && !ansValid) begin
				return;
			end
		end
		reportProblem("answers still pending after the timeout");
	endtask

	task automatic waitReqReadyLow();
		for (int waited = 0; waited < waitLimit; waited++) begin
			@(negedge clock);
			if (!reqReady) begin
				return;
			end
		end
		reportProblem("reqReady never fell while the pipeline was stalled");
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(negedge clock) begin
		readyState = xorshift(readyState);
		if (readyMode == readyLow) begin
			ansReady = 1'b0;
		end else if (readyMode == readyHigh) begin
			ansReady = 1'b1;
		end else begin
			ansReady = readyState[4] | readyState[9];
		end
	end

	// reference model, answers must leave in request order
	always @(posedge clock) begin : answerMonitor
		expected_t entry;
		if (!reset) begin
			if (ansValid && ansReady) begin
				if (expectQueue.size() == 0) begin
					reportProblem("answer arrived with no request pending");
				end else begin
					entry = expectQueue.pop_front();
					if (entry.isNoise) begin
						noiseSeen.push_back(ans.resLo);
					end else begin
						assert (ans.resLo == entry.resLo)
							else reportMismatch("ans.resLo", entry.resLo, ans.resLo);
					end
				end
			end
			if (stallPhase) begin
				assert (reqReady == (stallAccepts < 3))
					else reportMismatch("reqReady", idWord_t'(stallAccepts < 3), idWord_t'(reqReady));
				if (reqValid && reqReady) begin
					stallAccepts++;
				end
			end
			if (reqValid && reqReady) begin
				entry.isNoise = (req.index == 5'd31);
				entry.resLo = expectedLo(req.index, req.timer);
				expectQueue.push_back(entry);
			end
		end
	end

	afterReset: assert property (@(posedge clock) $fell(reset) |-> !ansValid && reqReady)
		else reportProblem("ansValid or reqReady wrong right after reset");

	ansStable: assert property (@(posedge clock) disable iff (reset)
		ansValid && !ansReady |=> ansValid && $stable(ans))
		else reportProblem("ans changed while ansValid was high and ansReady low");

	hiZero: assert property (@(posedge clock) disable iff (reset) ansValid |-> ans.resHi == '0)
		else reportMismatch("ans.resHi", '0, ans.resHi);

	initial begin
		logic allSame;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		ansReady = 1'b0;
		readyMode = readyHigh;
		stallPhase = 1'b0;
		stallAccepts = 0;
		stimState = 32'd21;
		readyState = 32'd21;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// every index once
		for (int i = 0; i < 32; i++) begin
			stimState = xorshift(stimState);
			sendRequest(queryIndex_t'(i), stimState[11:0]);
		end
		endRequests();
		drainAll();

		// random indices against a random consumer
		setReadyMode(readyRandom);
		for (int i = 0; i < 48; i++) begin
			stimState = xorshift(stimState);
			sendRequest(stimState[20:16], stimState[11:0]);
		end
		// noise burst
		for (int i = 0; i < 8; i++) begin
			stimState = xorshift(stimState);
			sendRequest(5'd31, stimState[11:0]);
		end
		endRequests();
		drainAll();

		// fill all three stages with the consumer stalled
		setReadyMode(readyLow);
		@(negedge clock);
		stallAccepts = 0;
		stallPhase = 1'b1;
		for (int i = 0; i < 3; i++) begin
			stimState = xorshift(stimState);
			sendRequest(queryIndex_t'(i), stimState[11:0]);
		end
		stimState = xorshift(stimState);
		driveRequest(5'd1, stimState[11:0]);
		waitReqReadyLow();
		repeat (4) @(posedge clock);
		setReadyMode(readyHigh);
		@(negedge clock);
		stallPhase = 1'b0;
		awaitAccept();
		endRequests();
		drainAll();

		allSame = 1'b1;
		for (int k = 1; k < noiseSeen.size(); k++) begin
			if (noiseSeen[k] != noiseSeen[0]) begin
				allSame = 1'b0;
			end
		end
		if (allSame) begin
			reportProblem("noise words from index 31 were all equal");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- cpuIdUnit.f
common/cpuIdConfigPkg.sv
common/cpuIdPipePkg.sv
src/noiseRng.sv
pipeline/queryDecode.sv
pipeline/queryExecute.sv
pipeline/queryResult.sv
src/cpuIdTop.sv
testbench/cpuIdTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the cpuIdUnit testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module cpuIdTb -f cpuIdUnit.f -o cpuIdSim &&
	./obj_dir/cpuIdSim ||
	{ echo "cpuIdUnit simulation did not pass"; exit 1; }
